// File: hdl/cache_pkg.sv
// cache package
// geometry of the 4-way read-only cache, the address view and the way number type
`default_nettype none

package cache_pkg;

    // geometry
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 8;

    // word address and data widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // address split, tag above index
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W;

    // way number within a set
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // tag and set index as the store sees them
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } cache_addr_fields_t;

    // one word address, forwarded raw or decoded into tag and index
    typedef union packed {
        logic [ADDR_W-1:0]  raw;
        cache_addr_fields_t fields;
    } cache_addr_u;

endpackage

`default_nettype wire

// File: hdl/cache_lookup_if.sv
// lookup and fill bus between the cache controller and the tag/data store
`timescale 1ns/1ns
`default_nettype none

interface cache_lookup_if import cache_pkg::*; ();

    // controller side
    logic              lookup;
    logic              fill;
    cache_addr_u       addr;
    logic [DATA_W-1:0] fill_data;

    // store side, registered one cycle after lookup
    logic              hit;
    logic [DATA_W-1:0] rdata;

    modport ctrl (
        output lookup,
        output fill,
        output addr,
        output fill_data,
        input  hit,
        input  rdata
    );

    modport store (
        input  lookup,
        input  fill,
        input  addr,
        input  fill_data,
        output hit,
        output rdata
    );

endinterface

`default_nettype wire

// File: hdl/repl_fifo.sv
// age-based replacement state for one cache set
// names the lowest-numbered way whose age has reached zero
`timescale 1ns/1ns
`default_nettype none

module repl_fifo #(
    parameter int unsigned SET_ASSOC = 4
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic [SET_ASSOC-1:0]         access,
    input  logic                         update,

    output logic [$clog2(SET_ASSOC)-1:0] repl_index
);

    // one age counter per way
    logic [$clog2(SET_ASSOC)-1:0] age      [SET_ASSOC];
    logic [$clog2(SET_ASSOC)-1:0] age_next [SET_ASSOC];
    logic [SET_ASSOC-1:0]         age_zero;
    logic [$clog2(SET_ASSOC)-1:0] zero_min;

    // only 2 and 4 ways are meant to be used
    if (SET_ASSOC != 2 && SET_ASSOC != 4) begin : g_bad_assoc
        $error("repl_fifo supports SET_ASSOC of 2 or 4 only");
    end

    for (genvar i = 0; i < SET_ASSOC; i++) begin : g_zero
        assign age_zero[i] = ~|age[i];
    end

    // priority encoder, lowest way wins
    always_comb begin
        zero_min = '0;
        for (int i = SET_ASSOC - 1; i >= 0; i--) begin
            if (age_zero[i]) begin
                zero_min = i[$clog2(SET_ASSOC)-1:0];
            end
        end
    end

    assign repl_index = zero_min;

    // accessed way goes to max age, the rest count down toward zero
    always_comb begin
        for (int i = 0; i < SET_ASSOC; i++) begin
            if (access[i]) begin
                age_next[i] = '1;
            end else if (!age_zero[i]) begin
                age_next[i] = age[i] - 1'b1;
            end else begin
                age_next[i] = age[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SET_ASSOC; i++) begin
                age[i] <= '0;
            end
        end else if (update) begin
            age <= age_next;
        end
    end

    // the store hands over a single hit or victim way per update
    a_access_onehot: assert property (@(posedge clk) disable iff (rst)
        update |-> $onehot0(access));

endmodule

`default_nettype wire

// File: hdl/tag_store.sv
// tag, valid and data arrays of the 4-way cache
// answers lookups one cycle later and writes the victim way on fill
`timescale 1ns/1ns
`default_nettype none

module tag_store import cache_pkg::*; (
    input  logic clk,
    input  logic rst,
    cache_lookup_if.store bus
);

    // storage, one word per line
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS][NUM_WAYS];
    logic [DATA_W-1:0]   data_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid    [NUM_SETS];

    logic [INDEX_W-1:0]  idx;
    logic [TAG_W-1:0]    tag;
    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] match;
    way_t                hit_way;
    logic                free_found;
    way_t                free_way;
    way_t                victim;
    logic [NUM_WAYS-1:0] victim_onehot;

    // per-set replacement hookup
    logic [NUM_SETS-1:0] set_update;
    logic [NUM_WAYS-1:0] set_access [NUM_SETS];
    way_t                set_repl   [NUM_SETS];

    assign idx       = bus.addr.fields.index;
    assign tag       = bus.addr.fields.tag;
    assign set_valid = valid[idx];

    // tag compare across the addressed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = set_valid[w] && (tag_mem[idx][w] == tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // empty ways are used before the age rule
    always_comb begin
        free_found = 1'b0;
        free_way   = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                free_found = 1'b1;
                free_way   = way_t'(w);
            end
        end
    end

    assign victim        = free_found ? free_way : set_repl[idx];
    assign victim_onehot = NUM_WAYS'(1) << victim;

    for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
        // a miss lookup leaves the ages alone
        assign set_update[s] = (idx == INDEX_W'(s)) && ((bus.lookup && |match) || bus.fill);
        assign set_access[s] = !set_update[s] ? '0 : (bus.fill ? victim_onehot : match);

        repl_fifo #(
            .SET_ASSOC (NUM_WAYS)
        ) u_repl (
            .clk        (clk),
            .rst        (rst),
            .access     (set_access[s]),
            .update     (set_update[s]),
            .repl_index (set_repl[s])
        );
    end

    // valid bits and the hit flag
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
            end
            bus.hit <= 1'b0;
        end else begin
            if (bus.lookup) begin
                bus.hit <= |match;
            end
            if (bus.fill) begin
                valid[idx][victim] <= 1'b1;
            end
        end
    end

    // line contents and read data
    always_ff @(posedge clk) begin
        if (bus.lookup) begin
            bus.rdata <= data_mem[idx][hit_way];
        end
        if (bus.fill) begin
            tag_mem[idx][victim]  <= tag;
            data_mem[idx][victim] <= bus.fill_data;
        end
    end

    a_no_lookup_with_fill: assert property (@(posedge clk) disable iff (rst)
        !(bus.lookup && bus.fill));

    // a line is never filled twice into one set
    a_single_match: assert property (@(posedge clk) disable iff (rst)
        bus.lookup |-> $onehot0(match));

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
// cache controller
// runs the requester and memory handshakes around lookup, fetch and fill
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // requester
    input  logic              req,
    output logic              ack,
    input  cache_addr_u       addr,
    output logic [DATA_W-1:0] rdata,
    output logic              hit,

    // backing memory
    output logic              mem_req,
    input  logic              mem_ack,
    output logic [ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_rdata,

    cache_lookup_if.ctrl      bus
);

    enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_WAIT,
        FILL,
        RESPOND,
        MEM_RELEASE
    } state;

    cache_addr_u addr_q;
    logic        lookup_q;
    logic        fill_q;
    logic        result_ready;

    // lookup pulse has gone by, store answer is on the bus
    assign result_ready = (state == LOOKUP) && !lookup_q;

    assign bus.lookup    = lookup_q;
    assign bus.fill      = fill_q;
    assign bus.addr      = addr_q;
    assign bus.fill_data = rdata;
    assign mem_addr      = addr_q.raw;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            ack      <= 1'b0;
            hit      <= 1'b0;
            mem_req  <= 1'b0;
            lookup_q <= 1'b0;
            fill_q   <= 1'b0;
        end else begin
            lookup_q <= 1'b0;
            fill_q   <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        lookup_q <= 1'b1;
                        state    <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (result_ready) begin
                        hit <= bus.hit;
                        if (bus.hit) begin
                            ack   <= 1'b1;
                            state <= RESPOND;
                        end else begin
                            mem_req <= 1'b1;
                            state   <= MEM_WAIT;
                        end
                    end
                end
                MEM_WAIT: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        fill_q  <= 1'b1;
                        state   <= FILL;
                    end
                end
                FILL: begin
                    ack   <= 1'b1;
                    state <= MEM_RELEASE;
                end
                MEM_RELEASE: begin
                    // memory must finish its handshake before the next request
                    if (!mem_ack) begin
                        if (!req) begin
                            ack   <= 1'b0;
                            state <= IDLE;
                        end else begin
                            state <= RESPOND;
                        end
                    end
                end
                RESPOND: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request address and returned word
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            addr_q <= addr;
        end
        if (result_ready && bus.hit) begin
            rdata <= bus.rdata;
        end
        if (state == MEM_WAIT && mem_ack) begin
            rdata <= mem_rdata;
        end
    end

    a_mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && $past(mem_req) |-> $stable(mem_addr));

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req);

endmodule

`default_nettype wire

// File: hdl/cache_top.sv
// read-only 4-way cache top level
// requester and backing memory handshakes as plain ports
`timescale 1ns/1ns
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              req,
    output logic              ack,
    input  logic [ADDR_W-1:0] addr,
    output logic [DATA_W-1:0] rdata,
    output logic              hit,

    output logic              mem_req,
    input  logic              mem_ack,
    output logic [ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_rdata
);

    cache_lookup_if lookup_bus ();

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .addr      (addr),
        .rdata     (rdata),
        .hit       (hit),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .bus       (lookup_bus.ctrl)
    );

    tag_store u_store (
        .clk (clk),
        .rst (rst),
        .bus (lookup_bus.store)
    );

endmodule

`default_nettype wire

// File: test/cache_tb.sv
// testbench for the 4-way read-only cache
// replays a request trace against a backing-memory model with random latency
`timescale 1ns/1ns
`default_nettype none

module cache_tb import cache_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              req;
    logic              ack;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rdata;
    logic              hit;
    logic              mem_req;
    logic              mem_ack;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_rdata;

    integer            seed;
    int                errors;
    int                checks;
    int                test_errors;
    bit                mem_seen;
    logic [ADDR_W-1:0] cur_addr;

    // trace contents, one entry per request
    int                trace_test [$];
    logic [ADDR_W-1:0] trace_addr [$];
    bit                trace_hit  [$];
    logic [DATA_W-1:0] trace_data [$];
    bit                trace_loaded;

    cache_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .addr      (addr),
        .rdata     (rdata),
        .hit       (hit),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("[FAIL] %0t %s: expected %h, got %h", $time, name, expected, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic load_trace();
        int                fd;
        int                n;
        int                test_num;
        int                h;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        string             line;
        fd = $fopen("test/cache_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open test/cache_trace.txt for reading");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // skip blank and comment lines
                if (n > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%d %h %d %h", test_num, a, h, d);
                    if (n == 4) begin
                        trace_test.push_back(test_num);
                        trace_addr.push_back(a);
                        trace_hit.push_back(h != 0);
                        trace_data.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
        trace_loaded = 1'b1;
    endtask

    // one full requester handshake for trace entry idx
    task automatic run_request(input int idx);
        @(negedge clk);
        cur_addr = trace_addr[idx];
        mem_seen = 1'b0;
        addr     = trace_addr[idx];
        req      = 1'b1;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        check_value("rdata", rdata, trace_data[idx]);
        check_value("hit", 32'(hit), 32'(trace_hit[idx]));
        check_value("mem_req seen", 32'(mem_seen), 32'(!trace_hit[idx]));
        // ack has to stay up as long as req does
        @(negedge clk);
        checks++;
        assert (ack) else begin
            $display("ack dropped at %0t while req was still high", $time);
            errors++;
            test_errors++;
        end
        req = 1'b0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end
    endtask

    // backing memory, answers after 1 to 6 cycles
    initial begin : memory_model
        int delay;
        forever begin
            @(negedge clk);
            if (mem_req && !mem_ack) begin
                mem_seen = 1'b1;
                check_value("mem_addr", 32'(mem_addr), 32'(cur_addr));
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay) @(negedge clk);
                mem_rdata = {16'h0000, mem_addr} ^ 32'hA5A5_0000;
                mem_ack   = 1'b1;
                while (mem_req) begin
                    @(negedge clk);
                end
                mem_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = trace_addr.size() * 40 + 200;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, a handshake never completed", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        int idx;
        int cur_test;
        int test_reqs;
        clk          = 1'b0;
        rst          = 1'b1;
        req          = 1'b0;
        addr         = '0;
        mem_ack      = 1'b0;
        mem_rdata    = '0;
        seed         = 32'h7cd2_9e0d;
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        mem_seen     = 1'b0;
        cur_addr     = '0;
        trace_loaded = 1'b0;
        load_trace();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (trace_addr.size() == 0) begin
            $display("the trace file holds no requests");
            errors++;
        end else begin
            cur_test  = trace_test[0];
            test_reqs = 0;
            for (idx = 0; idx < trace_addr.size(); idx++) begin
                if (trace_test[idx] != cur_test) begin
                    $display("test %0d: %0d requests, %0d errors", cur_test, test_reqs,
                             test_errors);
                    cur_test    = trace_test[idx];
                    test_reqs   = 0;
                    test_errors = 0;
                end
                run_request(idx);
                test_reqs++;
            end
            $display("test %0d: %0d requests, %0d errors", cur_test, test_reqs, test_errors);
        end

        $display("%0d requests, %0d checks, %0d errors", trace_addr.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hdl/cache_pkg.sv
hdl/cache_lookup_if.sv
hdl/repl_fifo.sv
hdl/tag_store.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
test/cache_tb.sv

// File: Makefile
# Verilator build and run of the cache testbench

all: run

obj_dir/Vcache_tb: build.f $(wildcard hdl/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert --top-module cache_tb -f build.f -o Vcache_tb

# the trace is read at run time, so the simulation runs from the project root
run: obj_dir/Vcache_tb
	./obj_dir/Vcache_tb | tee sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: test/cache_trace.txt
// test  addr(hex)  hit  data(hex)
// data is the address xor A5A50000; hit 1 means no memory fetch
1 0011 0 A5A50011
1 0011 1 A5A50011
1 0123 0 A5A50123
1 0123 1 A5A50123
2 0102 0 A5A50102
2 0202 0 A5A50202
2 0302 0 A5A50302
2 0402 0 A5A50402
2 0102 1 A5A50102
2 0202 1 A5A50202
2 0302 1 A5A50302
2 0402 1 A5A50402
3 1004 0 A5A51004
3 2004 0 A5A52004
3 3004 0 A5A53004
3 4004 0 A5A54004
3 2004 1 A5A52004
3 5004 0 A5A55004
3 1004 0 A5A51004
3 2004 1 A5A52004
3 5004 1 A5A55004
4 0785 0 A5A50785
4 0786 0 A5A50786
4 0787 0 A5A50787
4 0806 0 A5A50806
4 0906 0 A5A50906
4 0A06 0 A5A50A06
4 0B06 0 A5A50B06
4 0785 1 A5A50785
4 0787 1 A5A50787
4 0786 0 A5A50786
5 FFF7 0 A5A5FFF7
5 1237 0 A5A51237
5 FFF7 1 A5A5FFF7
5 ABCF 0 A5A5ABCF
5 1237 1 A5A51237
5 0000 0 A5A50000
5 0000 1 A5A50000
